// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tbLcCtrl
FILELIST = lcCtrlTop.f
PASS_MSG = test passed

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== lcCtrlFsm.sv ====
// Life-cycle sequencer from request accept through counter and state programming to response
`timescale 1ns/1ps
`default_nettype none

module lcCtrlFsm (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      transValid_i,
  output logic                      transReady_o,
  input  lcCtrlPkg::lcDecState_t    transTarget_i,
  output logic                      respValid_o,
  input  logic                      respReady_i,
  output lcCtrlPkg::lcStatus_e      respStatus_o,
  input  lcCtrlPkg::lcStateWord_t   stateWord_i,
  input  lcCtrlPkg::lcCntWord_t     cntWord_i,
  input  lcCtrlPkg::lcDecStateRep_t decState_i,
  input  logic                      decErr_i,
  lcTransIf.fsm                     trans,
  lcOtpIf.fsm                       otp
);
  import lcCtrlPkg::*;

  lcFsmState_e    stateQ;
  lcStatus_e      statusQ;
  logic           fatalQ;
  logic           progReqQ;
  lcDecStateRep_t targetQ;
  lcStateWord_t   curStateQ;
  lcCntWord_t     curCntQ;
  lcDecStateRep_t decStateQ;
  lcStateWord_t   progStateQ;
  lcCntWord_t     progCntQ;
  logic           accept;
  logic           stateErr;

  assign accept = transValid_i && transReady_o;

  // A corrupt store seen at a decision point or a refused program ends the sequence
  assign stateErr = (decErr_i && (stateQ inside {CntIncrSt, TransCheckSt})) ||
                    (otp.progDone && otp.progErr);

  assign transReady_o = (stateQ == IdleSt);
  assign respValid_o  = (stateQ == RespSt);
  assign respStatus_o = statusQ;

  // The query uses the words captured at accept, so the first program pass
  // cannot change what the edge check sees
  assign trans.curStateWord = curStateQ;
  assign trans.curCnt       = curCntQ;
  assign trans.decState     = decStateQ;
  assign trans.target       = targetQ;
  assign trans.fsmState     = stateQ;

  assign otp.progReq   = progReqQ;
  assign otp.progState = progStateQ;
  assign otp.progCnt   = progCntQ;

  // ------------------------------
  // Sequencer
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stateQ   <= IdleSt;
      statusQ  <= StatusOk;
      fatalQ   <= 1'b0;
      progReqQ <= 1'b0;
    end else begin
      // Program request is a one-cycle pulse
      progReqQ <= 1'b0;
      if (stateErr) begin
        statusQ <= StatusStateError;
        fatalQ  <= 1'b1;
        stateQ  <= RespSt;
      end else begin
        case (stateQ)
          IdleSt: begin
            if (accept) begin
              stateQ <= CntIncrSt;
            end
          end
          CntIncrSt: begin
            if (trans.cntOflwErr) begin
              statusQ <= StatusCntOverflow;
              stateQ  <= RespSt;
            end else begin
              progReqQ <= 1'b1;
              stateQ   <= CntProgSt;
            end
          end
          CntProgSt: begin
            if (otp.progDone) begin
              stateQ <= TransCheckSt;
            end
          end
          TransCheckSt: begin
            // The counter is already consumed when the edge turns out forbidden
            if (trans.transInvalidErr) begin
              statusQ <= StatusTransInvalid;
              stateQ  <= RespSt;
            end else begin
              progReqQ <= 1'b1;
              stateQ   <= TransProgSt;
            end
          end
          TransProgSt: begin
            if (otp.progDone) begin
              statusQ <= StatusOk;
              stateQ  <= RespSt;
            end
          end
          RespSt: begin
            // A fatal error parks the controller until reset
            if (respReady_i) begin
              stateQ <= fatalQ ? InvalidSt : IdleSt;
            end
          end
          InvalidSt: begin
            stateQ <= InvalidSt;
          end
          default: begin
            stateQ <= InvalidSt;
          end
        endcase
      end
    end
  end

  // ------------------------------
  // Request and program payload
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      targetQ   <= {DecLcStateNumRep{transTarget_i}};
      curStateQ <= stateWord_i;
      curCntQ   <= cntWord_i;
      decStateQ <= decState_i;
    end
    // Next words are sampled in the cycle before each program pulse
    if (stateQ inside {CntIncrSt, TransCheckSt}) begin
      progStateQ <= trans.nextStateWord;
      progCntQ   <= trans.nextCnt;
    end
  end

endmodule

`default_nettype wire

// ==== lcCtrlPkg.sv ====
// Life-cycle controller package with state and counter encodings, enums and transition rules
`default_nettype none

package lcCtrlPkg;

  // ------------------------------
  // Stored word encodings
  // ------------------------------

  // Encoded state word as it sits in the one-time-programmable store
  typedef logic [15:0] lcStateWord_t;

  // Every permitted edge only sets bits, so a legal transition never clears a fuse
  // Raw is the blank device and Scrap has every bit blown
  localparam lcStateWord_t LcStRaw           = 16'h0000;
  localparam lcStateWord_t LcStTestUnlocked0 = 16'h0001;
  localparam lcStateWord_t LcStTestLocked0   = 16'h0003;
  localparam lcStateWord_t LcStTestUnlocked1 = 16'h0007;
  localparam lcStateWord_t LcStDev           = 16'h00F7;
  localparam lcStateWord_t LcStProd          = 16'h0FF7;
  localparam lcStateWord_t LcStRma           = 16'h3FF7;
  localparam lcStateWord_t LcStScrap         = 16'hFFFF;

  // Thermometer-coded transition counter, a count of n is n low ones
  typedef logic [7:0] lcCntWord_t;

  localparam lcCntWord_t LcCnt0 = 8'h00;
  localparam lcCntWord_t LcCnt1 = 8'h01;
  localparam lcCntWord_t LcCnt2 = 8'h03;
  localparam lcCntWord_t LcCnt3 = 8'h07;
  localparam lcCntWord_t LcCnt4 = 8'h0F;
  localparam lcCntWord_t LcCnt5 = 8'h1F;
  localparam lcCntWord_t LcCnt6 = 8'h3F;
  localparam lcCntWord_t LcCnt7 = 8'h7F;
  localparam lcCntWord_t LcCnt8 = 8'hFF;

  // ------------------------------
  // Decoded representation
  // ------------------------------

  typedef logic [2:0] lcDecState_t;

  localparam int NumLcStates = 8;

  localparam lcDecState_t DecLcStRaw           = 3'd0;
  localparam lcDecState_t DecLcStTestUnlocked0 = 3'd1;
  localparam lcDecState_t DecLcStTestLocked0   = 3'd2;
  localparam lcDecState_t DecLcStTestUnlocked1 = 3'd3;
  localparam lcDecState_t DecLcStDev           = 3'd4;
  localparam lcDecState_t DecLcStProd          = 3'd5;
  localparam lcDecState_t DecLcStRma           = 3'd6;
  localparam lcDecState_t DecLcStScrap         = 3'd7;

  // The decoded index is carried twice so a single upset cannot pass the checks
  localparam int DecLcStateNumRep = 2;

  typedef lcDecState_t [DecLcStateNumRep-1:0] lcDecStateRep_t;

  // Decoded count from 0 to 8
  typedef logic [3:0] lcDecCnt_t;

  // ------------------------------
  // Transition matrix
  // ------------------------------

  // Row is the current state, bit position is the target state
  // Self-edges are all forbidden and Scrap is a dead end
  localparam logic [NumLcStates-1:0][NumLcStates-1:0] TransMatrix = {
    8'b0000_0000,  // Scrap
    8'b1000_0000,  // Rma
    8'b1100_0000,  // Prod
    8'b1110_0000,  // Dev
    8'b1111_0000,  // TestUnlocked1
    8'b1011_1000,  // TestLocked0
    8'b1111_0100,  // TestUnlocked0
    8'b1000_0010   // Raw
  };

  // Clock cycles from a program request to its done pulse
  localparam int OtpProgLatency = 4;
  localparam int OtpLatCntW     = $clog2(OtpProgLatency + 1);

  // ------------------------------
  // Sequencer and response types
  // ------------------------------

  typedef enum logic [2:0] {
    IdleSt,
    CntIncrSt,
    CntProgSt,
    TransCheckSt,
    TransProgSt,
    RespSt,
    InvalidSt
  } lcFsmState_e;

  typedef enum logic [1:0] {
    StatusOk,
    StatusTransInvalid,
    StatusCntOverflow,
    StatusStateError
  } lcStatus_e;

endpackage

`default_nettype wire

// ==== lcCtrlSva.sv ====
// Protocol assertions for the life-cycle sequencer and its programming port
`timescale 1ns/1ps
`default_nettype none

module lcCtrlSva (
  input logic                 clk_i,
  input logic                 reset_i,
  input logic                 transReady_o,
  input logic                 respValid_o,
  input logic                 respReady_i,
  input lcCtrlPkg::lcStatus_e respStatus_o,
  input logic                 progReq,
  input logic                 progDone,
  input logic                 progErr
);
  import lcCtrlPkg::*;

  // ------------------------------
  // Programming port
  // ------------------------------

  // Done arrives exactly the programming latency after the request
  progDoneAfterReqA: assert property (@(posedge clk_i) disable iff (reset_i)
    progReq |-> ##OtpProgLatency progDone)
    else $error("progDone missing %0d cycles after progReq", OtpProgLatency);

  // And never shows up without a matching request
  progDoneHasReqA: assert property (@(posedge clk_i) disable iff (reset_i)
    progDone |-> $past(progReq, OtpProgLatency))
    else $error("progDone without a progReq %0d cycles earlier", OtpProgLatency);

  // Legal sequences only ever set fuse bits
  noProgErrA: assert property (@(posedge clk_i) disable iff (reset_i)
    !progErr)
    else $error("progErr raised by the store");

  // ------------------------------
  // Host channels
  // ------------------------------

  // The request side only reopens once the pending response has been taken
  readyAfterRespA: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(transReady_o) |-> $past(respValid_o && respReady_i))
    else $error("transReady_o rose without an accepted response");

  // A stalled response keeps its valid and its status
  respStableA: assert property (@(posedge clk_i) disable iff (reset_i)
    (respValid_o && !respReady_i) |=> (respValid_o && $stable(respStatus_o)))
    else $error("Response changed while stalled");

endmodule

bind lcCtrlFsm lcCtrlSva uSva (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .transReady_o (transReady_o),
  .respValid_o  (respValid_o),
  .respReady_i  (respReady_i),
  .respStatus_o (respStatus_o),
  .progReq      (otp.progReq),
  .progDone     (otp.progDone),
  .progErr      (otp.progErr)
);

`default_nettype wire

// ==== lcCtrlTop.f ====
lcCtrlPkg.sv
lcTransIf.sv
lcOtpIf.sv
lcOtpStore.sv
lcStateDecoder.sv
lcStateTransition.sv
lcCtrlFsm.sv
lcCtrlTop.sv
lcCtrlSva.sv
tbLcCtrl.sv

// ==== lcCtrlTop.sv ====
// Life-cycle controller top level joining store, decoder, transition function and sequencer
`timescale 1ns/1ps
`default_nettype none

module lcCtrlTop (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   transValid_i,
  output logic                   transReady_o,
  input  lcCtrlPkg::lcDecState_t transTarget_i,
  output logic                   respValid_o,
  input  logic                   respReady_i,
  output lcCtrlPkg::lcStatus_e   respStatus_o,
  output lcCtrlPkg::lcDecState_t lcState_o,
  output lcCtrlPkg::lcDecCnt_t   lcCnt_o
);
  import lcCtrlPkg::*;

  lcStateWord_t   stateWord;
  lcCntWord_t     cntWord;
  lcDecStateRep_t decState;
  lcDecCnt_t      decCnt;
  logic           decErr;

  lcTransIf transIf ();
  lcOtpIf   otpIf ();

  // Fuse array with its programming port
  lcOtpStore uOtpStore (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .otp         (otpIf.store),
    .stateWord_o (stateWord),
    .cntWord_o   (cntWord)
  );

  // Live decode of whatever the store holds right now
  lcStateDecoder uStateDecoder (
    .stateWord_i (stateWord),
    .cntWord_i   (cntWord),
    .decState_o  (decState),
    .decCnt_o    (decCnt),
    .decErr_o    (decErr)
  );

  lcStateTransition uStateTransition (
    .trans (transIf.trans)
  );

  lcCtrlFsm uCtrlFsm (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .transValid_i  (transValid_i),
    .transReady_o  (transReady_o),
    .transTarget_i (transTarget_i),
    .respValid_o   (respValid_o),
    .respReady_i   (respReady_i),
    .respStatus_o  (respStatus_o),
    .stateWord_i   (stateWord),
    .cntWord_i     (cntWord),
    .decState_i    (decState),
    .decErr_i      (decErr),
    .trans         (transIf.fsm),
    .otp           (otpIf.fsm)
  );

  // Replica 0 is shown to the outside
  assign lcState_o = decState[0];
  assign lcCnt_o   = decCnt;

endmodule

`default_nettype wire

// ==== lcOtpIf.sv ====
// Programming port between the life-cycle sequencer and the one-time-programmable store
`timescale 1ns/1ps
`default_nettype none

interface lcOtpIf;
  import lcCtrlPkg::*;

  // Single-cycle request with the full words to be programmed
  logic         progReq;
  lcStateWord_t progState;
  lcCntWord_t   progCnt;

  // Done pulses a fixed latency after the request, error is only valid with done
  logic         progDone;
  logic         progErr;

  modport fsm (
    output progReq, progState, progCnt,
    input  progDone, progErr
  );

  modport store (
    input  progReq, progState, progCnt,
    output progDone, progErr
  );

endinterface

`default_nettype wire

// ==== lcOtpStore.sv ====
// Behavioural one-time-programmable store for the life-cycle state and counter words
`timescale 1ns/1ps
`default_nettype none

module lcOtpStore (
  input  logic                 clk_i,
  input  logic                 reset_i,
  lcOtpIf.store                otp,
  output lcCtrlPkg::lcStateWord_t stateWord_o,
  output lcCtrlPkg::lcCntWord_t   cntWord_o
);
  import lcCtrlPkg::*;

  lcStateWord_t          stateWord;
  lcCntWord_t            cntWord;
  lcStateWord_t          pendState;
  lcCntWord_t            pendCnt;
  logic                  busy;
  logic [OtpLatCntW-1:0] latCnt;
  logic                  clearsBits;

  // A fuse that is already blown can never go back to zero
  assign clearsBits = ((stateWord & ~pendState) != '0) || ((cntWord & ~pendCnt) != '0);

  // Done fires in the cycle where the latency counter has run out
  assign otp.progDone = busy && (latCnt == '0);
  assign otp.progErr  = otp.progDone && clearsBits;

  assign stateWord_o = stateWord;
  assign cntWord_o   = cntWord;

  // Control path and the fuse array itself
  // Reset stands in for power-on of a blank device
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy      <= 1'b0;
      latCnt    <= '0;
      stateWord <= LcStRaw;
      cntWord   <= LcCnt0;
    end else if (otp.progDone) begin
      busy <= 1'b0;
      // Nothing is written at all when the new words would clear a bit
      if (!clearsBits) begin
        stateWord <= pendState;
        cntWord   <= pendCnt;
      end
    end else if (busy) begin
      latCnt <= latCnt - 1'b1;
    end else if (otp.progReq) begin
      busy   <= 1'b1;
      latCnt <= OtpLatCntW'(OtpProgLatency - 1);
    end
  end

  // Words waiting to be burnt
  always_ff @(posedge clk_i) begin
    if (otp.progReq && !busy) begin
      pendState <= otp.progState;
      pendCnt   <= otp.progCnt;
    end
  end

endmodule

`default_nettype wire

// ==== lcStateDecoder.sv ====
// Life-cycle word decoder producing a replicated state index and a binary count
`timescale 1ns/1ps
`default_nettype none

module lcStateDecoder (
  input  lcCtrlPkg::lcStateWord_t   stateWord_i,
  input  lcCtrlPkg::lcCntWord_t     cntWord_i,
  output lcCtrlPkg::lcDecStateRep_t decState_o,
  output lcCtrlPkg::lcDecCnt_t      decCnt_o,
  output logic                      decErr_o
);
  import lcCtrlPkg::*;

  lcDecState_t decIdx;
  logic        stateErr;
  logic        cntErr;

  // Only the eight exact encodings are accepted, anything else is a corrupt store
  always_comb begin
    decIdx   = DecLcStRaw;
    stateErr = 1'b0;
    case (stateWord_i)
      LcStRaw:           decIdx = DecLcStRaw;
      LcStTestUnlocked0: decIdx = DecLcStTestUnlocked0;
      LcStTestLocked0:   decIdx = DecLcStTestLocked0;
      LcStTestUnlocked1: decIdx = DecLcStTestUnlocked1;
      LcStDev:           decIdx = DecLcStDev;
      LcStProd:          decIdx = DecLcStProd;
      LcStRma:           decIdx = DecLcStRma;
      LcStScrap:         decIdx = DecLcStScrap;
      default:           stateErr = 1'b1;
    endcase
  end

  // Thermometer to binary, a gap in the ones is flagged
  always_comb begin
    decCnt_o = '0;
    cntErr   = 1'b0;
    case (cntWord_i)
      LcCnt0:  decCnt_o = 4'd0;
      LcCnt1:  decCnt_o = 4'd1;
      LcCnt2:  decCnt_o = 4'd2;
      LcCnt3:  decCnt_o = 4'd3;
      LcCnt4:  decCnt_o = 4'd4;
      LcCnt5:  decCnt_o = 4'd5;
      LcCnt6:  decCnt_o = 4'd6;
      LcCnt7:  decCnt_o = 4'd7;
      LcCnt8:  decCnt_o = 4'd8;
      default: cntErr = 1'b1;
    endcase
  end

  // Same index goes into every replica
  assign decState_o = {DecLcStateNumRep{decIdx}};
  assign decErr_o   = stateErr || cntErr;

endmodule

`default_nettype wire

// ==== lcStateTransition.sv ====
// Life-cycle transition function that checks an edge and computes the next stored words
`timescale 1ns/1ps
`default_nettype none

module lcStateTransition (
  lcTransIf.trans trans
);
  import lcCtrlPkg::*;

  logic repMatch;
  logic edgeOk;
  logic toScrap;

  // Both replicas of the current state and of the target have to agree
  assign repMatch = (trans.decState[0] == trans.decState[1]) &&
                    (trans.target[0] == trans.target[1]);

  // Each replica indexes the matrix on its own and both must allow the edge
  assign edgeOk = TransMatrix[trans.decState[0]][trans.target[0]] &&
                  TransMatrix[trans.decState[1]][trans.target[1]];

  assign toScrap = (trans.target == {DecLcStateNumRep{DecLcStScrap}});

  always_comb begin
    // Defaults keep the stored words unchanged
    trans.nextStateWord   = trans.curStateWord;
    trans.nextCnt         = trans.curCnt;
    trans.cntOflwErr      = 1'b0;
    trans.transInvalidErr = 1'b0;

    // ------------------------------
    // Counter increment
    // ------------------------------
    // The increment stays asserted through the check so the second program
    // pass carries the same counter word as the first one
    if (trans.fsmState inside {CntIncrSt, CntProgSt, TransCheckSt}) begin
      case (trans.curCnt)
        LcCnt0:  trans.nextCnt = LcCnt1;
        LcCnt1:  trans.nextCnt = LcCnt2;
        LcCnt2:  trans.nextCnt = LcCnt3;
        LcCnt3:  trans.nextCnt = LcCnt4;
        LcCnt4:  trans.nextCnt = LcCnt5;
        LcCnt5:  trans.nextCnt = LcCnt6;
        LcCnt6:  trans.nextCnt = LcCnt7;
        LcCnt7:  trans.nextCnt = LcCnt8;
        default: trans.cntOflwErr = 1'b1;
      endcase

      // Scrap is always reachable, so the overflow is silenced here
      // The counter is maxed out and the state word is already forced to Scrap,
      // which means Scrap gets burnt once with the counter and once more later
      if (toScrap) begin
        trans.nextCnt       = LcCnt8;
        trans.nextStateWord = LcStScrap;
        trans.cntOflwErr    = 1'b0;
      end
    end

    // ------------------------------
    // Edge check and target encoding
    // ------------------------------
    if (trans.fsmState inside {TransCheckSt, TransProgSt}) begin
      if (repMatch && edgeOk) begin
        case (trans.target[0])
          DecLcStRaw:           trans.nextStateWord = LcStRaw;
          DecLcStTestUnlocked0: trans.nextStateWord = LcStTestUnlocked0;
          DecLcStTestLocked0:   trans.nextStateWord = LcStTestLocked0;
          DecLcStTestUnlocked1: trans.nextStateWord = LcStTestUnlocked1;
          DecLcStDev:           trans.nextStateWord = LcStDev;
          DecLcStProd:          trans.nextStateWord = LcStProd;
          DecLcStRma:           trans.nextStateWord = LcStRma;
          DecLcStScrap:         trans.nextStateWord = LcStScrap;
          default:              trans.transInvalidErr = 1'b1;
        endcase
      end else begin
        // Mismatching replicas are treated like a forbidden edge
        trans.transInvalidErr = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== lcTransIf.sv ====
// Transition query interface between the life-cycle sequencer and the transition function
`timescale 1ns/1ps
`default_nettype none

interface lcTransIf;
  import lcCtrlPkg::*;

  // Query, owned by the sequencer
  lcStateWord_t   curStateWord;
  lcCntWord_t     curCnt;
  lcDecStateRep_t decState;
  lcDecStateRep_t target;
  lcFsmState_e    fsmState;

  // Answer, combinational and valid in the same cycle as the query
  lcStateWord_t   nextStateWord;
  lcCntWord_t     nextCnt;
  logic           cntOflwErr;
  logic           transInvalidErr;

  modport fsm (
    output curStateWord, curCnt, decState, target, fsmState,
    input  nextStateWord, nextCnt, cntOflwErr, transInvalidErr
  );

  modport trans (
    input  curStateWord, curCnt, decState, target, fsmState,
    output nextStateWord, nextCnt, cntOflwErr, transInvalidErr
  );

endinterface

`default_nettype wire

// ==== tbLcCtrl.sv ====
// Directed testbench for the life-cycle controller with a transition model and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tbLcCtrl;
  import lcCtrlPkg::*;

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 16;
  // Requests issued over all tests, each one gets 20 cycles
  localparam int NumRequests    = 17;
  localparam int WatchdogCycles = NumRequests * 20 + 2 * ResetCycles;

  // Legal walk from a blank device up to Rma
  localparam lcDecState_t LegalWalk [6] = '{DecLcStTestUnlocked0, DecLcStTestLocked0,
    DecLcStTestUnlocked1, DecLcStDev, DecLcStProd, DecLcStRma};

  logic        clk_i;
  logic        reset_i;
  logic        transValid_i;
  logic        transReady_o;
  lcDecState_t transTarget_i;
  logic        respValid_o;
  logic        respReady_i;
  lcStatus_e   respStatus_o;
  lcDecState_t lcState_o;
  lcDecCnt_t   lcCnt_o;

  // Model of what the store should hold
  lcDecState_t mState;
  int          mCnt;
  int          errCount;
  int          testsOk;
  int          testsBad;
  integer      seed;

  lcCtrlTop uut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .transValid_i  (transValid_i),
    .transReady_o  (transReady_o),
    .transTarget_i (transTarget_i),
    .respValid_o   (respValid_o),
    .respReady_i   (respReady_i),
    .respStatus_o  (respStatus_o),
    .lcState_o     (lcState_o),
    .lcCnt_o       (lcCnt_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout, the tests did not finish within %0d cycles", WatchdogCycles);
    $display("test failed");
    $finish;
  end

  // ------------------------------
  // Checking and model helpers
  // ------------------------------

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      errCount++;
      $display("Error %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic checkTrue(input logic cond, input string what);
    assert (cond) else begin
      errCount++;
      $display("%s", what);
    end
  endtask

  // Permitted edges, Scrap is reachable from every other state
  function automatic logic edgeAllowed(input lcDecState_t cur, input lcDecState_t tgt);
    logic ok;
    ok = 1'b0;
    if (tgt == DecLcStScrap) begin
      ok = (cur != DecLcStScrap);
    end else begin
      case (cur)
        DecLcStRaw:           ok = (tgt == DecLcStTestUnlocked0);
        DecLcStTestUnlocked0: ok = tgt inside {DecLcStTestLocked0, DecLcStDev, DecLcStProd,
                                               DecLcStRma};
        DecLcStTestLocked0:   ok = tgt inside {DecLcStTestUnlocked1, DecLcStDev, DecLcStProd};
        DecLcStTestUnlocked1: ok = tgt inside {DecLcStDev, DecLcStProd, DecLcStRma};
        DecLcStDev:           ok = tgt inside {DecLcStProd, DecLcStRma};
        DecLcStProd:          ok = (tgt == DecLcStRma);
        default:              ok = 1'b0;
      endcase
    end
    return ok;
  endfunction

  function automatic int randomHold();
    return $random(seed) & 3;
  endfunction

  task automatic applyReset();
    @(negedge clk_i);
    reset_i = 1'b1;
    repeat (ResetCycles) @(negedge clk_i);
    reset_i = 1'b0;
    mState  = DecLcStRaw;
    mCnt    = 0;
  endtask

  // One request, a response held back for holdCycles, then the store contents
  task automatic runRequest(input lcDecState_t target, input int holdCycles);
    lcStatus_e expStatus;
    lcStatus_e heldStatus;
    int        expLat;
    int        lat;
    int        i;
    // Counter is burnt first, so a forbidden edge still uses up one step
    if (mCnt == 8 && target != DecLcStScrap) begin
      expStatus = StatusCntOverflow;
      expLat    = 0;
    end else begin
      mCnt = (target == DecLcStScrap) ? 8 : mCnt + 1;
      if (edgeAllowed(mState, target)) begin
        expStatus = StatusOk;
        expLat    = 12;
        mState    = target;
      end else begin
        expStatus = StatusTransInvalid;
        expLat    = 7;
      end
    end
    transValid_i  = 1'b1;
    transTarget_i = target;
    while (!transReady_o) @(negedge clk_i);
    @(negedge clk_i);
    transValid_i = 1'b0;
    lat = 0;
    while (!respValid_o && lat < 40) begin
      @(negedge clk_i);
      lat++;
    end
    checkTrue(respValid_o, "No response within 40 cycles of the request");
    heldStatus = respStatus_o;
    for (i = 0; i < holdCycles; i++) begin
      @(negedge clk_i);
      checkValue("respValid_o", 32'(respValid_o), 32'd1);
      checkValue("transReady_o", 32'(transReady_o), 32'd0);
      checkValue("respStatus_o", 32'(respStatus_o), 32'(heldStatus));
    end
    checkValue("respStatus_o", 32'(heldStatus), 32'(expStatus));
    if (expLat != 0) begin
      checkValue("respValid_o latency", lat, expLat);
    end
    respReady_i = 1'b1;
    @(negedge clk_i);
    respReady_i = 1'b0;
    checkValue("respValid_o", 32'(respValid_o), 32'd0);
    checkValue("transReady_o", 32'(transReady_o), 32'd1);
    checkValue("lcState_o", 32'(lcState_o), 32'(mState));
    checkValue("lcCnt_o", 32'(lcCnt_o), 32'(mCnt));
  endtask

  task automatic walkFromRaw(input int steps);
    int i;
    for (i = 0; i < steps; i++) begin
      runRequest(LegalWalk[i], randomHold());
    end
  endtask

  task automatic reportTest(input string name, input int startErr);
    if (errCount == startErr) begin
      testsOk++;
      $display("%s: ok", name);
    end else begin
      testsBad++;
      $display("%s: FAIL with %0d errors", name, errCount - startErr);
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic resetState();
    int startErr;
    startErr = errCount;
    applyReset();
    checkValue("lcState_o", 32'(lcState_o), 32'(DecLcStRaw));
    checkValue("lcCnt_o", 32'(lcCnt_o), 32'd0);
    checkValue("transReady_o", 32'(transReady_o), 32'd1);
    checkValue("respValid_o", 32'(respValid_o), 32'd0);
    reportTest("resetState", startErr);
  endtask

  task automatic legalPath();
    int startErr;
    startErr = errCount;
    walkFromRaw(6);
    reportTest("legalPath", startErr);
  endtask

  // Fresh device walked up to Prod, then a backward edge and a self-edge
  task automatic forbiddenEdges();
    int startErr;
    startErr = errCount;
    applyReset();
    walkFromRaw(5);
    runRequest(DecLcStDev, randomHold());
    runRequest(DecLcStProd, randomHold());
    reportTest("forbiddenEdges", startErr);
  endtask

  // The eighth request uses the last step, after that only Scrap goes through
  task automatic counterExhaustion();
    int startErr;
    startErr = errCount;
    runRequest(DecLcStRma, randomHold());
    runRequest(DecLcStDev, randomHold());
    runRequest(DecLcStScrap, randomHold());
    reportTest("counterExhaustion", startErr);
  endtask

  task automatic backPressure();
    int startErr;
    startErr = errCount;
    runRequest(DecLcStScrap, 6);
    reportTest("backPressure", startErr);
  endtask

  initial begin
    seed          = 32'ha092b833;
    errCount      = 0;
    testsOk       = 0;
    testsBad      = 0;
    reset_i       = 1'b1;
    transValid_i  = 1'b0;
    transTarget_i = DecLcStRaw;
    respReady_i   = 1'b0;
    mState        = DecLcStRaw;
    mCnt          = 0;
    resetState();
    legalPath();
    forbiddenEdges();
    counterExhaustion();
    backPressure();
    $display("Tests ok %0d, failing %0d, failed checks %0d", testsOk, testsBad, errCount);
    if (errCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
